// File: rtl/rob_types_pkg.sv
`default_nettype none

package rob_types_pkg;

  // data, pc and branch target all share the machine word
  typedef logic [31:0] rob_data_t;

  typedef logic [4:0] arch_reg_t;   // architectural register number

  // branch kind as carried from decode
  typedef enum logic [1:0] {
    BR_NONE = 2'b00,  // ordinary instruction
    BR_CALL = 2'b01,
    BR_RET  = 2'b10,
    BR_JUMP = 2'b11   // conditional branch or jump
  } br_kind_t;

  // one reorder-buffer record, written whole at dispatch
  typedef struct packed {
    logic      complete;  // result ready, may retire
    br_kind_t  br_kind;
    logic      br_right;  // prediction was right
    logic      taken;     // resolved direction
    rob_data_t target;    // resolved target
    rob_data_t pc;
    logic      rd_en;     // writes a destination register
    arch_reg_t rd_arch;
    rob_data_t result;
  } rob_entry_t;

  function automatic logic is_branch(br_kind_t kind);
    return kind != BR_NONE;
  endfunction

endpackage

`default_nettype wire

// File: rtl/rob_io_pkg.sv
`default_nettype none

package rob_io_pkg;

  import rob_types_pkg::*;

  // alu writeback, tag travels beside it
  typedef struct packed {
    logic      valid;
    rob_data_t result;
  } alu_wb_t;

  // branch unit writeback
  // prediction flag and target each have their own enable,
  // the direction is always written
  typedef struct packed {
    logic      valid;
    logic      right_en;   // update br_right
    logic      right;
    logic      taken;
    logic      target_en;  // update target
    rob_data_t target;
  } bru_wb_t;

  // one retire slot as seen by the commit stage
  typedef struct packed {
    logic      valid;
    br_kind_t  br_kind;
    logic      br_right;
    logic      taken;
    rob_data_t target;
    rob_data_t pc;
    logic      rd_en;
    arch_reg_t rd_arch;
    rob_data_t result;
  } commit_t;

endpackage

`default_nettype wire

// File: rtl/rob_ptr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rob_ptr_ctrl #(
  parameter int DEPTH = 64
) (
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire logic                       recover,
  input  wire logic                       stall,
  input  wire logic                       alloc0,
  input  wire logic                       alloc1,
  input  wire logic [1:0]                 commit_num,
  output logic      [$clog2(DEPTH)-1:0]   alloc_tag0,
  output logic      [$clog2(DEPTH)-1:0]   alloc_tag1,
  output logic      [$clog2(DEPTH)-1:0]   head_tag,
  output logic                            full,
  output logic                            empty,
  output logic                            two_avail
);

  localparam int TAG_W = $clog2(DEPTH);

  logic [TAG_W-1:0] head;
  logic [TAG_W-1:0] tail;
  logic [TAG_W:0]   count;      // one extra bit so DEPTH fits
  logic [TAG_W:0]   free_cnt;
  logic [1:0]       alloc_num;
  logic             alloc_ok;

  assign free_cnt  = (TAG_W+1)'(DEPTH) - count;
  assign full      = free_cnt < (TAG_W+1)'(2);  // room for a full pair only
  assign empty     = count == '0;
  assign two_avail = count >= (TAG_W+1)'(2);

  // all or nothing, nothing at all while stalled or full
  assign alloc_ok = alloc0 && !stall && !full;

  always_comb begin
    alloc_num = 2'd0;
    if (alloc_ok) begin
      alloc_num = alloc1 ? 2'd2 : 2'd1;
    end
  end

  // tags wrap through the natural width of the pointer
  assign alloc_tag0 = tail;
  assign alloc_tag1 = tail + 1'b1;
  assign head_tag   = head;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (recover) begin
      // flush, the next allocation starts at tag 0
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      tail  <= tail + TAG_W'(alloc_num);
      head  <= head + TAG_W'(commit_num);   // commit keeps running under stall
      count <= count + (TAG_W+1)'(alloc_num) - (TAG_W+1)'(commit_num);
    end
  end

endmodule

`default_nettype wire

// File: rtl/rob_entry_store.sv
`timescale 1ns/1ps
`default_nettype none

module rob_entry_store
  import rob_types_pkg::*, rob_io_pkg::*;
#(
  parameter int DEPTH = 64
) (
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire logic                       recover,
  input  wire logic                       stall,
  input  wire logic                       disp0_en,
  input  wire logic [$clog2(DEPTH)-1:0]   disp0_tag,
  input  wire rob_entry_t                 disp0_entry,
  input  wire logic                       disp1_en,
  input  wire logic [$clog2(DEPTH)-1:0]   disp1_tag,
  input  wire rob_entry_t                 disp1_entry,
  input  wire alu_wb_t                    alu_wb,
  input  wire logic [$clog2(DEPTH)-1:0]   alu_tag,
  input  wire bru_wb_t                    bru_wb,
  input  wire logic [$clog2(DEPTH)-1:0]   bru_tag,
  input  wire logic [$clog2(DEPTH)-1:0]   head_tag,
  output rob_entry_t                      head_entry0,
  output rob_entry_t                      head_entry1
);

  localparam int TAG_W = $clog2(DEPTH);

  rob_entry_t       mem [DEPTH];      // payload, complete bit kept separately
  logic [DEPTH-1:0] complete_q;
  logic [TAG_W-1:0] head_tag1;

  // record payload
  // later statements win, so the alu beats dispatch on the same slot
  always_ff @(posedge clk) begin
    if (!stall) begin
      if (disp0_en) begin
        mem[disp0_tag] <= disp0_entry;
      end
      if (disp1_en) begin
        mem[disp1_tag] <= disp1_entry;
      end
      if (bru_wb.valid) begin
        mem[bru_tag].taken <= bru_wb.taken;
        if (bru_wb.right_en) begin
          mem[bru_tag].br_right <= bru_wb.right;
        end
        if (bru_wb.target_en) begin
          mem[bru_tag].target <= bru_wb.target;
        end
      end
      if (alu_wb.valid) begin
        mem[alu_tag].result <= alu_wb.result;
      end
    end
  end

  // complete flags, the only per-entry state that reset and flush touch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      complete_q <= '0;
    end else if (recover) begin
      complete_q <= '0;
    end else if (!stall) begin
      // a retired slot keeps its old flag until dispatch rewrites it
      if (disp0_en) complete_q[disp0_tag] <= disp0_entry.complete;
      if (disp1_en) complete_q[disp1_tag] <= disp1_entry.complete;
      if (bru_wb.valid) complete_q[bru_tag] <= 1'b1;
      if (alu_wb.valid) complete_q[alu_tag] <= 1'b1;
    end
  end

  assign head_tag1 = head_tag + 1'b1;   // wraps modulo DEPTH

  always_comb begin
    head_entry0          = mem[head_tag];
    head_entry0.complete = complete_q[head_tag];
    head_entry1          = mem[head_tag1];
    head_entry1.complete = complete_q[head_tag1];
  end

endmodule

`default_nettype wire

// File: rtl/rob_commit_sel.sv
`timescale 1ns/1ps
`default_nettype none

module rob_commit_sel
  import rob_types_pkg::*, rob_io_pkg::*;
#(
  parameter int DEPTH = 64
) (
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire logic                       recover,
  input  wire logic [$clog2(DEPTH)-1:0]   head_tag,
  input  wire rob_entry_t                 head_entry0,
  input  wire rob_entry_t                 head_entry1,
  input  wire logic                       empty,
  input  wire logic                       two_avail,
  output logic      [1:0]                 commit_num,
  output commit_t                         commit0,
  output commit_t                         commit1,
  output logic      [$clog2(DEPTH)-1:0]   commit_tag0,
  output logic      [$clog2(DEPTH)-1:0]   commit_tag1
);

  localparam int TAG_W = $clog2(DEPTH);

  logic             br0;
  logic             br1;
  logic             retire0;
  logic             retire1;
  logic [TAG_W-1:0] head_tag1;

  function automatic commit_t to_commit(rob_entry_t e);
    commit_t c;
    c.valid    = 1'b1;
    c.br_kind  = e.br_kind;
    c.br_right = e.br_right;
    c.taken    = e.taken;
    c.target   = e.target;
    c.pc       = e.pc;
    c.rd_en    = e.rd_en;
    c.rd_arch  = e.rd_arch;
    c.result   = e.result;
    return c;
  endfunction

  assign br0       = is_branch(head_entry0.br_kind);
  assign br1       = is_branch(head_entry1.br_kind);
  assign head_tag1 = head_tag + 1'b1;

  // in-order retire, the oldest entry gates everything behind it
  assign retire0 = !empty && head_entry0.complete;

  // a mispredicted branch retires alone, and never two branches together
  assign retire1 = retire0 && two_avail && head_entry1.complete &&
                   !(br0 && !head_entry0.br_right) &&
                   !(br0 && br1);

  assign commit_num = retire1 ? 2'd2 : (retire0 ? 2'd1 : 2'd0);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      commit0     <= '0;
      commit1     <= '0;
      commit_tag0 <= '0;
      commit_tag1 <= '0;
    end else if (recover) begin
      commit0     <= '0;
      commit1     <= '0;
      commit_tag0 <= '0;
      commit_tag1 <= '0;
    end else begin
      commit0     <= retire0 ? to_commit(head_entry0) : '0;
      commit_tag0 <= retire0 ? head_tag : '0;
      commit1     <= retire1 ? to_commit(head_entry1) : '0;
      commit_tag1 <= retire1 ? head_tag1 : '0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/rob_top.sv
`timescale 1ns/1ps
`default_nettype none

module rob_top
  import rob_types_pkg::*, rob_io_pkg::*;
#(
  parameter int DEPTH = 64
) (
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire logic                       recover,
  input  wire logic                       stall,
  input  wire logic                       alloc0,
  input  wire logic                       alloc1,
  input  wire logic                       disp0_en,
  input  wire logic [$clog2(DEPTH)-1:0]   disp0_tag,
  input  wire rob_entry_t                 disp0_entry,
  input  wire logic                       disp1_en,
  input  wire logic [$clog2(DEPTH)-1:0]   disp1_tag,
  input  wire rob_entry_t                 disp1_entry,
  input  wire alu_wb_t                    alu_wb,
  input  wire logic [$clog2(DEPTH)-1:0]   alu_tag,
  input  wire bru_wb_t                    bru_wb,
  input  wire logic [$clog2(DEPTH)-1:0]   bru_tag,
  output logic      [$clog2(DEPTH)-1:0]   alloc_tag0,
  output logic      [$clog2(DEPTH)-1:0]   alloc_tag1,
  output logic                            full,
  output logic                            empty,
  output commit_t                         commit0,
  output commit_t                         commit1,
  output logic      [$clog2(DEPTH)-1:0]   commit_tag0,
  output logic      [$clog2(DEPTH)-1:0]   commit_tag1
);

  localparam int TAG_W = $clog2(DEPTH);

  logic [TAG_W-1:0] head_tag;
  logic [1:0]       commit_num;   // same-cycle feedback to the head pointer
  logic             two_avail;
  rob_entry_t       head_entry0;
  rob_entry_t       head_entry1;

  rob_ptr_ctrl #(.DEPTH(DEPTH)) u_ptr_ctrl (
    .clk, .reset, .recover, .stall,
    .alloc0, .alloc1, .commit_num,
    .alloc_tag0, .alloc_tag1, .head_tag,
    .full, .empty, .two_avail
  );

  rob_entry_store #(.DEPTH(DEPTH)) u_entry_store (
    .clk, .reset, .recover, .stall,
    .disp0_en, .disp0_tag, .disp0_entry,
    .disp1_en, .disp1_tag, .disp1_entry,
    .alu_wb, .alu_tag, .bru_wb, .bru_tag,
    .head_tag, .head_entry0, .head_entry1
  );

  rob_commit_sel #(.DEPTH(DEPTH)) u_commit_sel (
    .clk, .reset, .recover,
    .head_tag, .head_entry0, .head_entry1, .empty, .two_avail,
    .commit_num, .commit0, .commit1, .commit_tag0, .commit_tag1
  );

endmodule

`default_nettype wire

// File: dv/rob_props.sv
`timescale 1ns/1ps
`default_nettype none

module rob_props #(
  parameter int DEPTH = 64
) (
  input wire logic                   clk,
  input wire logic                   reset,
  input wire logic                   full,
  input wire logic                   empty,
  input wire logic [1:0]             commit_num,
  input wire logic [$clog2(DEPTH):0] count,
  input wire logic                   commit0_valid,
  input wire logic                   commit1_valid
);

  // slot 1 only ever retires behind slot 0
  assert property (@(posedge clk) disable iff (reset)
    !(commit1_valid && !commit0_valid))
    else $error("commit slot 1 valid without slot 0");

  assert property (@(posedge clk) disable iff (reset)
    !(full && empty))
    else $error("full and empty both high");

  // never retire more than is held
  assert property (@(posedge clk) disable iff (reset)
    ($clog2(DEPTH)+1)'(commit_num) <= count)
    else $error("commit_num exceeds occupancy");

endmodule

bind rob_top rob_props #(.DEPTH(DEPTH)) u_props (
  .clk           (clk),
  .reset         (reset),
  .full          (full),
  .empty         (empty),
  .commit_num    (commit_num),
  .count         (u_ptr_ctrl.count),
  .commit0_valid (commit0.valid),
  .commit1_valid (commit1.valid)
);

`default_nettype wire

// File: dv/rob_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rob_tb
  import rob_types_pkg::*, rob_io_pkg::*;
();

  localparam int DEPTH   = 16;
  localparam int TAG_W   = $clog2(DEPTH);
  localparam int TIMEOUT = 200;

  logic             clk;
  logic             reset;
  logic             recover;
  logic             stall;
  logic             alloc0;
  logic             alloc1;
  logic             disp0_en;
  logic             disp1_en;
  logic [TAG_W-1:0] disp0_tag;
  logic [TAG_W-1:0] disp1_tag;
  logic [TAG_W-1:0] alu_tag;
  logic [TAG_W-1:0] bru_tag;
  logic [TAG_W-1:0] alloc_tag0;
  logic [TAG_W-1:0] alloc_tag1;
  logic [TAG_W-1:0] commit_tag0;
  logic [TAG_W-1:0] commit_tag1;
  rob_entry_t       disp0_entry;
  rob_entry_t       disp1_entry;
  alu_wb_t          alu_wb;
  bru_wb_t          bru_wb;
  logic             full;
  logic             empty;
  commit_t          commit0;
  commit_t          commit1;

  logic [15:0] lfsr_state;
  rob_entry_t  model_rec [DEPTH];   // records by tag, as the DUT should hold them
  int          model_q[$];          // allocated tags, oldest first
  int          model_tail;
  int          exp_n;               // entries expected to retire at the last edge
  rob_entry_t  exp_rec [2];
  int          exp_tag [2];

  rob_top #(.DEPTH(DEPTH)) uut (
    .clk, .reset, .recover, .stall, .alloc0, .alloc1,
    .disp0_en, .disp0_tag, .disp0_entry, .disp1_en, .disp1_tag, .disp1_entry,
    .alu_wb, .alu_tag, .bru_wb, .bru_tag,
    .alloc_tag0, .alloc_tag1, .full, .empty,
    .commit0, .commit1, .commit_tag0, .commit_tag1
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // galois lfsr, one step per bit
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = (lfsr_state >> 1) ^ (b ? 16'hB400 : 16'h0000);
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) r = {r[30:0], lfsr_bit()};
    return r;
  endfunction

  function automatic rob_entry_t rand_entry(logic complete, br_kind_t kind);
    rob_entry_t e;
    e.complete = complete;
    e.br_kind  = kind;
    e.br_right = lfsr_bit();
    e.taken    = lfsr_bit();
    e.target   = rand_bits(32);
    e.pc       = rand_bits(32);
    e.rd_en    = lfsr_bit();
    e.rd_arch  = 5'(rand_bits(5));
    e.result   = rand_bits(32);
    return e;
  endfunction

  // expected retire count from the two oldest entries
  function automatic int retire_count(rob_entry_t e0, rob_entry_t e1, int cnt);
    logic br0;
    logic br1;
    br0 = e0.br_kind != BR_NONE;
    br1 = e1.br_kind != BR_NONE;
    if (cnt == 0 || !e0.complete) return 0;
    if (cnt < 2 || !e1.complete) return 1;
    if (br0 && !e0.br_right) return 1;   // mispredict goes alone
    if (br0 && br1) return 1;
    return 2;
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic timeout_fail(string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_slot(commit_t c, logic [TAG_W-1:0] tag, int slot);
    string s;
    s = $sformatf("commit%0d", slot);
    check_value({s, ".valid"}, 32'(c.valid), 32'(slot < exp_n));
    if (slot < exp_n) begin
      check_value({s, "_tag"}, 32'(tag), 32'(exp_tag[slot]));
      check_value({s, ".br_kind"}, 32'(c.br_kind), 32'(exp_rec[slot].br_kind));
      check_value({s, ".br_right"}, 32'(c.br_right), 32'(exp_rec[slot].br_right));
      check_value({s, ".taken"}, 32'(c.taken), 32'(exp_rec[slot].taken));
      check_value({s, ".target"}, c.target, exp_rec[slot].target);
      check_value({s, ".pc"}, c.pc, exp_rec[slot].pc);
      check_value({s, ".rd_en"}, 32'(c.rd_en), 32'(exp_rec[slot].rd_en));
      check_value({s, ".rd_arch"}, 32'(c.rd_arch), 32'(exp_rec[slot].rd_arch));
      check_value({s, ".result"}, c.result, exp_rec[slot].result);
    end else begin
      check_value({s, "_tag"}, 32'(tag), 32'd0);
      check_value({s, " payload"}, 32'(|c), 32'd0);   // idle slot is all zero
    end
  endtask

  // model update, reads the inputs the DUT samples at this edge
  always @(posedge clk) begin : model_update
    rob_entry_t e0;
    rob_entry_t e1;
    int         cnt;
    if (reset || recover) begin
      model_q.delete();
      model_tail = 0;
      exp_n      = 0;
      for (int i = 0; i < DEPTH; i++) model_rec[i].complete = 1'b0;
    end else begin
      cnt = model_q.size();
      e0  = (cnt > 0) ? model_rec[model_q[0]] : '0;
      e1  = (cnt > 1) ? model_rec[model_q[1]] : '0;
      exp_n = retire_count(e0, e1, cnt);
      for (int i = 0; i < exp_n; i++) begin
        exp_tag[i] = model_q[0];
        exp_rec[i] = model_rec[model_q.pop_front()];
      end
      if (!stall) begin
        if (alloc0 && (DEPTH - cnt) >= 2) begin
          model_q.push_back(model_tail);
          model_tail = (model_tail + 1) % DEPTH;
          if (alloc1) begin
            model_q.push_back(model_tail);
            model_tail = (model_tail + 1) % DEPTH;
          end
        end
        if (disp0_en) model_rec[disp0_tag] = disp0_entry;
        if (disp1_en) model_rec[disp1_tag] = disp1_entry;
        if (bru_wb.valid) begin
          model_rec[bru_tag].complete = 1'b1;
          model_rec[bru_tag].taken    = bru_wb.taken;
          if (bru_wb.right_en) model_rec[bru_tag].br_right = bru_wb.right;
          if (bru_wb.target_en) model_rec[bru_tag].target = bru_wb.target;
        end
        if (alu_wb.valid) begin
          model_rec[alu_tag].complete = 1'b1;
          model_rec[alu_tag].result   = alu_wb.result;
        end
      end
    end
  end

  // compare at the falling edge, all outputs settled
  always @(negedge clk) begin
    if (!reset) begin
      check_value("full", 32'(full), 32'((DEPTH - model_q.size()) < 2));
      check_value("empty", 32'(empty), 32'(model_q.size() == 0));
      check_value("alloc_tag0", 32'(alloc_tag0), 32'(model_tail));
      check_value("alloc_tag1", 32'(alloc_tag1), 32'((model_tail + 1) % DEPTH));
      check_slot(commit0, commit_tag0, 0);
      check_slot(commit1, commit_tag1, 1);
    end
  end

  task automatic clear_inputs();
    alloc0   <= 1'b0;
    alloc1   <= 1'b0;
    disp0_en <= 1'b0;
    disp1_en <= 1'b0;
    alu_wb   <= '0;
    bru_wb   <= '0;
    stall    <= 1'b0;
    recover  <= 1'b0;
  endtask

  // allocate and dispatch in one cycle, the cycle before is always idle
  task automatic issue(rob_entry_t e0, rob_entry_t e1, logic two, output int tag0,
                       output int tag1);
    int waited;
    waited = 0;
    @(negedge clk);
    while (full) begin
      waited++;
      if (waited > TIMEOUT) timeout_fail("a free entry");
      @(negedge clk);
    end
    tag0 = int'(alloc_tag0);
    tag1 = int'(alloc_tag1);
    @(posedge clk);
    alloc0      <= 1'b1;
    alloc1      <= two;
    disp0_en    <= 1'b1;
    disp0_tag   <= alloc_tag0;
    disp0_entry <= e0;
    disp1_en    <= two;
    disp1_tag   <= alloc_tag1;
    disp1_entry <= e1;
    @(posedge clk);
    clear_inputs();
  endtask

  task automatic alu_write(int tag, logic [31:0] value);
    @(posedge clk);
    alu_wb  <= '{valid: 1'b1, result: value};
    alu_tag <= TAG_W'(tag);
    @(posedge clk);
    clear_inputs();
  endtask

  task automatic bru_write(int tag, logic re, logic r, logic tk, logic te, logic [31:0] tg);
    @(posedge clk);
    bru_wb  <= '{valid: 1'b1, right_en: re, right: r, taken: tk, target_en: te, target: tg};
    bru_tag <= TAG_W'(tag);
    @(posedge clk);
    clear_inputs();
  endtask

  // a request that must hand out nothing, either stalled or full
  task automatic blocked_request(logic with_stall);
    @(posedge clk);
    stall  <= with_stall;
    alloc0 <= 1'b1;
    alloc1 <= 1'b1;
    @(posedge clk);
    clear_inputs();
  endtask

  task automatic pulse_recover();
    @(posedge clk);
    recover <= 1'b1;
    @(posedge clk);
    clear_inputs();
  endtask

  task automatic wait_empty();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!empty) begin
      waited++;
      if (waited > TIMEOUT) timeout_fail("the buffer to drain");
      @(negedge clk);
    end
  endtask

  initial begin
    int         t0;
    int         t1;
    int         tags[$];
    rob_entry_t a;
    rob_entry_t b;
    lfsr_state  = 16'd48;
    reset       = 1'b1;
    recover     = 1'b0;
    stall       = 1'b0;
    alloc0      = 1'b0;
    alloc1      = 1'b0;
    disp0_en    = 1'b0;
    disp1_en    = 1'b0;
    disp0_tag   = '0;
    disp1_tag   = '0;
    disp0_entry = '0;
    disp1_entry = '0;
    alu_wb      = '0;
    alu_tag     = '0;
    bru_wb      = '0;
    bru_tag     = '0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    repeat (6) @(posedge clk);   // idle, nothing may commit
    @(negedge clk);
    check_value("empty", 32'(empty), 32'd1);
    check_value("full", 32'(full), 32'd0);

    // complete plain entries, pairs and singles, enough to wrap
    for (int k = 0; k < 12; k++) begin
      a = rand_entry(1'b1, BR_NONE);
      b = rand_entry(1'b1, BR_NONE);
      issue(a, b, (k % 3) != 0, t0, t1);
    end
    wait_empty();

    // fill with incomplete entries up to one free slot
    for (int k = 0; k < DEPTH / 2; k++) begin
      issue(rand_entry(1'b0, BR_NONE), rand_entry(1'b0, BR_NONE), k < DEPTH / 2 - 1,
            t0, t1);
      tags.push_back(t0);
      if (k < DEPTH / 2 - 1) tags.push_back(t1);
    end
    @(negedge clk);
    check_value("full", 32'(full), 32'd1);
    blocked_request(1'b0);
    blocked_request(1'b1);

    // finish out of order, odd positions first
    for (int k = 1; k < tags.size(); k += 2) alu_write(tags[k], rand_bits(32));
    for (int k = 0; k < tags.size(); k += 2) alu_write(tags[k], rand_bits(32));
    wait_empty();
    blocked_request(1'b1);   // stalled while not full

    // mispredicted head branch, then two branches back to back
    a = rand_entry(1'b1, BR_JUMP);
    a.br_right = 1'b0;
    issue(a, rand_entry(1'b1, BR_NONE), 1'b1, t0, t1);
    wait_empty();
    a = rand_entry(1'b1, BR_CALL);
    a.br_right = 1'b1;
    issue(a, rand_entry(1'b1, BR_RET), 1'b1, t0, t1);
    wait_empty();
    issue(a, rand_entry(1'b1, BR_NONE), 1'b1, t0, t1);   // right branch pairs up
    wait_empty();

    // branch unit writeback, every enable combination
    tags.delete();
    for (int k = 0; k < 2; k++) begin
      issue(rand_entry(1'b0, BR_JUMP), rand_entry(1'b0, BR_JUMP), 1'b1, t0, t1);
      tags.push_back(t0);
      tags.push_back(t1);
    end
    for (int k = 0; k < 4; k++) begin
      bru_write(tags[k], k[0], lfsr_bit(), lfsr_bit(), k[1], rand_bits(32));
    end
    wait_empty();

    // flush with work in flight
    for (int k = 0; k < 3; k++) begin
      issue(rand_entry(1'b0, BR_NONE), rand_entry(1'b0, BR_NONE), 1'b1, t0, t1);
    end
    alu_write(t1, rand_bits(32));
    pulse_recover();
    @(negedge clk);
    check_value("empty", 32'(empty), 32'd1);
    check_value("alloc_tag0", 32'(alloc_tag0), 32'd0);
    repeat (4) @(posedge clk);
    issue(rand_entry(1'b1, BR_NONE), a, 1'b0, t0, t1);
    check_value("tag after recover", 32'(t0), 32'd0);
    wait_empty();
    @(posedge clk);   // let the last falling-edge compare finish

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
rtl/rob_types_pkg.sv
rtl/rob_io_pkg.sv
rtl/rob_ptr_ctrl.sv
rtl/rob_entry_store.sv
rtl/rob_commit_sel.sv
rtl/rob_top.sv
dv/rob_props.sv
dv/rob_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the reorder buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module rob_tb -o rob_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/rob_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Test completed successfully$" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
